//--- source/sha256_pkg.sv
package sha256_pkg;

	typedef logic [31:0] word_t;

	// Working variables of one compression, a in the top word.
	typedef struct packed {
		word_t a;
		word_t b;
		word_t c;
		word_t d;
		word_t e;
		word_t f;
		word_t g;
		word_t h;
	} hash_state_t;

	// Position 0 holds the word for the current round, 1 to 15 the history.
	typedef logic [15:0][31:0] schedule_t;

	localparam word_t PAD_WORD = 32'h8000_0000; // Single set bit after the message.

	localparam word_t K_TABLE [64] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	function automatic word_t round_k(input int unsigned index);
		return K_TABLE[index];
	endfunction

	// Length field of the last block, for a message of msg_bits bits.
	function automatic word_t LEN_WORD(input int unsigned msg_bits);
		return word_t'(msg_bits);
	endfunction

	function automatic hash_state_t init_state();
		return '{32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
			32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19};
	endfunction

	function automatic word_t rotr(input word_t x, input int unsigned n);
		return (x >> n) | (x << (32 - n));
	endfunction

	function automatic word_t big_sigma0(input word_t x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic word_t big_sigma1(input word_t x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	function automatic word_t small_sigma0(input word_t x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic word_t small_sigma1(input word_t x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

	function automatic word_t choose(input word_t e, input word_t f, input word_t g);
		return (e & f) ^ (~e & g);
	endfunction

	function automatic word_t majority(input word_t a, input word_t b, input word_t c);
		return (a & b) ^ (a & c) ^ (b & c);
	endfunction

	function automatic hash_state_t add_state(input hash_state_t x, input hash_state_t y);
		return '{x.a + y.a, x.b + y.b, x.c + y.c, x.d + y.d,
			x.e + y.e, x.f + y.f, x.g + y.g, x.h + y.h};
	endfunction

	// One compression round with message word w and round constant k.
	function automatic hash_state_t sha_round(input hash_state_t s, input word_t w,
		input word_t k);
		word_t t1;
		word_t t2;
		hash_state_t r;
		t1 = s.h + big_sigma1(s.e) + choose(s.e, s.f, s.g) + k + w;
		t2 = big_sigma0(s.a) + majority(s.a, s.b, s.c);
		r.a = t1 + t2;
		r.b = s.a;
		r.c = s.b;
		r.d = s.c;
		r.e = s.d + t1;
		r.f = s.e;
		r.g = s.f;
		r.h = s.g;
		return r;
	endfunction

endpackage

//--- source/miner_pkg.sv
package miner_pkg;

	typedef logic [31:0] nonce_t;

	// One mining job as the host hands it over.
	typedef struct packed {
		sha256_pkg::hash_state_t midstate; // State after the first 64-byte chunk.
		sha256_pkg::word_t merkle_tail;
		sha256_pkg::word_t timestamp;
		sha256_pkg::word_t bits;
	} job_t;

	// Sweeper states. IDLE is only seen after reset, DONE after a finished sweep.
	typedef enum logic [1:0] {
		SWEEP_IDLE,
		SWEEP_RUN,
		SWEEP_DONE
	} sweep_state_t;

endpackage

//--- source/sha_round_stage.sv
`timescale 1ns/1ps

module sha_round_stage #(
	parameter sha256_pkg::word_t K = 32'h0,
	parameter bit EXPAND = 1'b1
) (
	input logic clk,
	input logic arst_n_i,
	input logic valid_i,
	input logic newblock_i,
	input sha256_pkg::hash_state_t state_i,
	input sha256_pkg::schedule_t sched_i,
	output logic valid_o,
	output logic newblock_o,
	output sha256_pkg::hash_state_t state_o,
	output sha256_pkg::schedule_t sched_o
);

	sha256_pkg::word_t next_w;

	// Expanded word W[i+1] from W[i-1], W[i-6], W[i-14] and W[i-15].
	always_comb begin
		if (EXPAND) begin
			next_w = sha256_pkg::small_sigma1(sched_i[15]) + sched_i[10]
				+ sha256_pkg::small_sigma0(sched_i[2]) + sched_i[1];
		end else begin
			next_w = sched_i[1]; // Message words are still in the window.
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_o <= 1'b0;
			newblock_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
			newblock_o <= newblock_i;
		end
	end

	// The used word moves to the back of the history.
	always_ff @(posedge clk) begin
		state_o <= sha256_pkg::sha_round(state_i, sched_i[0], K);
		sched_o <= {sched_i[0], sched_i[15:2], next_w};
	end

	// A new block marker must never travel without a valid candidate.
	a_newblock_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
		newblock_o |-> valid_o);

endmodule

//--- source/sha_pre_stage.sv
`timescale 1ns/1ps

module sha_pre_stage #(
	parameter int NONCE_BITS = 32
) (
	input logic clk,
	input logic arst_n_i,
	input logic job_start_i,
	input logic run_i,
	input sha256_pkg::hash_state_t midstate_i,
	input sha256_pkg::word_t merkle_tail_i,
	input sha256_pkg::word_t timestamp_i,
	input sha256_pkg::word_t bits_i,
	output logic busy_o,
	output logic valid_o,
	output logic newblock_o,
	output sha256_pkg::hash_state_t state_o,
	output sha256_pkg::schedule_t sched_o,
	output sha256_pkg::hash_state_t midstate_o
);

	localparam miner_pkg::nonce_t LAST_NONCE =
		miner_pkg::nonce_t'((64'd1 << NONCE_BITS) - 64'd1);

	miner_pkg::job_t job_q;
	miner_pkg::sweep_state_t sweep_q;
	miner_pkg::nonce_t nonce_q;
	logic first_q; // Next issue is the first of its job.
	logic issue;
	sha256_pkg::schedule_t msg_w;
	logic [15:1] valid_q;
	logic [15:1] nb_q;
	sha256_pkg::hash_state_t st_q [1:15];
	sha256_pkg::schedule_t msg_q [1:15];

	assign busy_o = (sweep_q == miner_pkg::SWEEP_RUN);
	assign issue = busy_o && run_i;

	always_ff @(posedge clk) begin
		if (job_start_i) begin
			job_q <= '{midstate: midstate_i, merkle_tail: merkle_tail_i,
				timestamp: timestamp_i, bits: bits_i};
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			sweep_q <= miner_pkg::SWEEP_IDLE;
			nonce_q <= '0;
			first_q <= 1'b0;
			valid_q <= '0;
			nb_q <= '0;
		end else begin
			valid_q <= {valid_q[14:1], issue};
			nb_q <= {nb_q[14:1], issue & first_q};
			if (job_start_i) begin // A new job abandons the running sweep.
				sweep_q <= miner_pkg::SWEEP_RUN;
				nonce_q <= '0;
				first_q <= 1'b1;
			end else if (issue) begin
				nonce_q <= nonce_q + 1'b1;
				first_q <= 1'b0;
				if (nonce_q == LAST_NONCE)
					sweep_q <= miner_pkg::SWEEP_DONE;
			end
		end
	end

	// Second chunk of the header holds tail, time, bits, nonce and the padding.
	always_comb begin
		msg_w = '0;
		msg_w[0] = job_q.merkle_tail;
		msg_w[1] = job_q.timestamp;
		msg_w[2] = job_q.bits;
		msg_w[3] = nonce_q;
		msg_w[4] = sha256_pkg::PAD_WORD;
		msg_w[15] = sha256_pkg::LEN_WORD(640);
	end

	// Rounds 0 to 14 take their word straight from the carried message.
	always_ff @(posedge clk) begin
		st_q[1] <= sha256_pkg::sha_round(job_q.midstate, msg_w[0], sha256_pkg::round_k(0));
		msg_q[1] <= msg_w;
		for (int i = 1; i < 15; i++) begin
			st_q[i + 1] <= sha256_pkg::sha_round(st_q[i], msg_q[i][i], sha256_pkg::round_k(i));
			msg_q[i + 1] <= msg_q[i];
		end
	end

	assign valid_o = valid_q[15];
	assign newblock_o = nb_q[15];
	assign state_o = st_q[15];
	assign sched_o = {msg_q[15][14:0], msg_q[15][15]}; // W15 first, then W0 to W14.
	assign midstate_o = job_q.midstate;

	// The first candidate of a job carries nonce 0, as the share detector assumes.
	a_first_nonce_zero: assert property (@(posedge clk) disable iff (!arst_n_i)
		nb_q[1] |-> (msg_q[1][3] == '0));

	// The sweep stops after the last nonce, so no candidate leaves the range.
	a_issue_in_range: assert property (@(posedge clk) disable iff (!arst_n_i)
		valid_q[1] |-> (msg_q[1][3] <= LAST_NONCE));

endmodule

//--- source/sha_pad_stage.sv
`timescale 1ns/1ps

module sha_pad_stage (
	input logic clk,
	input logic arst_n_i,
	input logic valid_i,
	input logic newblock_i,
	input sha256_pkg::hash_state_t state_i,
	input sha256_pkg::hash_state_t midstate_i,
	output logic valid_o,
	output logic newblock_o,
	output sha256_pkg::schedule_t sched_o
);

	sha256_pkg::hash_state_t digest;

	// Feed-forward of the second chunk closes the first hash.
	assign digest = sha256_pkg::add_state(state_i, midstate_i);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_o <= 1'b0;
			newblock_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
			newblock_o <= newblock_i;
		end
	end

	// A 256-bit digest fits one block together with its padding.
	always_ff @(posedge clk) begin
		sched_o <= {sha256_pkg::LEN_WORD(256), 192'h0, sha256_pkg::PAD_WORD,
			digest.h, digest.g, digest.f, digest.e,
			digest.d, digest.c, digest.b, digest.a};
	end

endmodule

//--- source/sha_double_core.sv
`timescale 1ns/1ps

module sha_double_core #(
	parameter int NONCE_BITS = 32
) (
	input logic clk,
	input logic arst_n_i,
	input logic job_start_i,
	input logic run_i,
	input sha256_pkg::hash_state_t midstate_i,
	input sha256_pkg::word_t merkle_tail_i,
	input sha256_pkg::word_t timestamp_i,
	input sha256_pkg::word_t bits_i,
	output logic busy_o,
	output logic valid_o,
	output logic newblock_o,
	output sha256_pkg::hash_state_t digest_o
);

	// Index i of each pipeline is the input of round i.
	logic h1_valid [15:64];
	logic h1_newblock [15:64];
	sha256_pkg::hash_state_t h1_state [15:64];
	sha256_pkg::schedule_t h1_sched [15:64];

	logic h2_valid [0:64];
	logic h2_newblock [0:64];
	sha256_pkg::hash_state_t h2_state [0:64];
	sha256_pkg::schedule_t h2_sched [0:64];

	sha256_pkg::hash_state_t mid_pre;
	sha256_pkg::hash_state_t mid_dly [1:64];

	sha_pre_stage #(.NONCE_BITS(NONCE_BITS)) u_pre (.clk, .arst_n_i, .job_start_i, .run_i,
		.midstate_i, .merkle_tail_i, .timestamp_i, .bits_i, .busy_o,
		.valid_o(h1_valid[15]), .newblock_o(h1_newblock[15]), .state_o(h1_state[15]),
		.sched_o(h1_sched[15]), .midstate_o(mid_pre));

	for (genvar i = 15; i < 64; i++) begin : g_hash1
		sha_round_stage #(.K(sha256_pkg::round_k(i)), .EXPAND(1'b1)) u_round (.clk,
			.arst_n_i, .valid_i(h1_valid[i]), .newblock_i(h1_newblock[i]),
			.state_i(h1_state[i]), .sched_i(h1_sched[i]), .valid_o(h1_valid[i + 1]),
			.newblock_o(h1_newblock[i + 1]), .state_o(h1_state[i + 1]),
			.sched_o(h1_sched[i + 1]));
	end

	// The midstate of each candidate meets it again at index 64.
	always_ff @(posedge clk) begin
		mid_dly[1] <= mid_pre;
		for (int k = 1; k < 64; k++)
			mid_dly[k + 1] <= mid_dly[k];
	end

	sha_pad_stage u_pad (.clk, .arst_n_i, .valid_i(h1_valid[64]),
		.newblock_i(h1_newblock[64]), .state_i(h1_state[64]), .midstate_i(mid_dly[64]),
		.valid_o(h2_valid[0]), .newblock_o(h2_newblock[0]), .sched_o(h2_sched[0]));

	assign h2_state[0] = sha256_pkg::init_state();

	for (genvar i = 0; i < 64; i++) begin : g_hash2
		sha_round_stage #(.K(sha256_pkg::round_k(i)), .EXPAND(i >= 15)) u_round (.clk,
			.arst_n_i, .valid_i(h2_valid[i]), .newblock_i(h2_newblock[i]),
			.state_i(h2_state[i]), .sched_i(h2_sched[i]), .valid_o(h2_valid[i + 1]),
			.newblock_o(h2_newblock[i + 1]), .state_o(h2_state[i + 1]),
			.sched_o(h2_sched[i + 1]));
	end

	assign digest_o = sha256_pkg::add_state(h2_state[64], sha256_pkg::init_state());
	assign valid_o = h2_valid[64];
	assign newblock_o = h2_newblock[64];

endmodule

//--- source/share_detector.sv
`timescale 1ns/1ps

module share_detector #(
	parameter int NONCE_BITS = 32,
	parameter int ZERO_BITS = 32
) (
	input logic clk,
	input logic arst_n_i,
	input logic valid_i,
	input logic newblock_i,
	input sha256_pkg::hash_state_t digest_i,
	output logic valid_o,
	output logic newblock_o,
	output logic hit_o,
	output miner_pkg::nonce_t nonce_o,
	output sha256_pkg::hash_state_t hash_o
);

	miner_pkg::nonce_t cnt_q; // Nonce expected for the next result.
	miner_pkg::nonce_t cur_nonce;
	logic hit;

	// Results leave the core in issue order, so counting recovers the nonce.
	assign cur_nonce = newblock_i ? '0 : cnt_q;
	assign hit = (digest_i.h[31 -: ZERO_BITS] == '0);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cnt_q <= '0;
			valid_o <= 1'b0;
			newblock_o <= 1'b0;
			hit_o <= 1'b0;
		end else begin
			if (valid_i)
				cnt_q <= cur_nonce + 1'b1;
			valid_o <= valid_i;
			newblock_o <= valid_i & newblock_i;
			hit_o <= valid_i & hit;
		end
	end

	always_ff @(posedge clk) begin
		nonce_o <= cur_nonce;
		hash_o <= digest_i;
	end

	a_nonce_range: assert property (@(posedge clk) disable iff (!arst_n_i)
		valid_i |-> (64'(cur_nonce) < (64'd1 << NONCE_BITS)));

endmodule

//--- source/sha_miner_top.sv
`timescale 1ns/1ps

module sha_miner_top #(
	parameter int NONCE_BITS = 32,
	parameter int ZERO_BITS = 32
) (
	input logic clk,
	input logic arst_n_i,
	input logic job_start_i,
	input logic run_i,
	input sha256_pkg::hash_state_t midstate_i,
	input sha256_pkg::word_t merkle_tail_i,
	input sha256_pkg::word_t timestamp_i,
	input sha256_pkg::word_t bits_i,
	output logic busy_o,
	output logic valid_o,
	output logic newblock_o,
	output logic hit_o,
	output miner_pkg::nonce_t nonce_o,
	output sha256_pkg::hash_state_t hash_o
);

	logic core_valid;
	logic core_newblock;
	sha256_pkg::hash_state_t core_digest; // Double hash, one cycle before the outputs.

	sha_double_core #(.NONCE_BITS(NONCE_BITS)) u_core (
		.clk,
		.arst_n_i,
		.job_start_i,
		.run_i,
		.midstate_i,
		.merkle_tail_i,
		.timestamp_i,
		.bits_i,
		.busy_o,
		.valid_o(core_valid),
		.newblock_o(core_newblock),
		.digest_o(core_digest)
	);

	share_detector #(.NONCE_BITS(NONCE_BITS), .ZERO_BITS(ZERO_BITS)) u_detect (
		.clk,
		.arst_n_i,
		.valid_i(core_valid),
		.newblock_i(core_newblock),
		.digest_i(core_digest),
		.valid_o,
		.newblock_o,
		.hit_o,
		.nonce_o,
		.hash_o
	);

endmodule

//--- test/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
	parameter int RESET_CYCLES = 16
) (
	output logic clk_o,
	output logic arst_n_o
);

	initial begin
		clk_o = 1'b0;
		arst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		arst_n_o = 1'b1; // Released away from the active edge.
	end

	always #20 clk_o = ~clk_o; // 40 ns period.

endmodule

//--- test/miner_tb.sv
`timescale 1ns/1ps

module miner_tb;

	logic clk;
	logic arst_n;
	logic job_start_i;
	logic run_i;
	sha256_pkg::hash_state_t midstate_i;
	sha256_pkg::word_t merkle_tail_i;
	sha256_pkg::word_t timestamp_i;
	sha256_pkg::word_t bits_i;
	logic busy_o;
	logic valid_o;
	logic newblock_o;
	logic hit_o;
	miner_pkg::nonce_t nonce_o;
	sha256_pkg::hash_state_t hash_o;

	sha256_pkg::hash_state_t j_mid [8];
	sha256_pkg::word_t j_tail [8];
	sha256_pkg::word_t j_time [8];
	sha256_pkg::word_t j_bits [8];
	int j_gap [8];
	int j_delay [8];
	int j_start [8];
	int j_err [8];
	int njobs = 0;
	int limit = 200;
	int cyc = 0;
	int errors = 0;
	int checks = 0;
	int jobs_done = 0;
	logic [31:0] lfsr = 32'h55952dea;

	clock_gen #(.RESET_CYCLES(16)) u_clk (.clk_o(clk), .arst_n_o(arst_n));

	sha_miner_top #(.NONCE_BITS(4), .ZERO_BITS(2)) dut_i (.clk, .arst_n_i(arst_n),
		.job_start_i, .run_i, .midstate_i, .merkle_tail_i, .timestamp_i, .bits_i,
		.busy_o, .valid_o, .newblock_o, .hit_o, .nonce_o, .hash_o);

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? 32'ha300_0000 : 32'h0);
	endfunction

	function automatic sha256_pkg::word_t ror(input sha256_pkg::word_t x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	// Reference compression with feed-forward, written from the standard.
	function automatic sha256_pkg::hash_state_t compress(input sha256_pkg::hash_state_t iv,
		input sha256_pkg::word_t m [16]);
		sha256_pkg::word_t w [64];
		sha256_pkg::word_t v [8];
		sha256_pkg::word_t t1;
		sha256_pkg::word_t t2;
		for (int i = 0; i < 16; i++)
			w[i] = m[i];
		for (int i = 16; i < 64; i++)
			w[i] = (ror(w[i-2], 17) ^ ror(w[i-2], 19) ^ (w[i-2] >> 10)) + w[i-7]
				+ (ror(w[i-15], 7) ^ ror(w[i-15], 18) ^ (w[i-15] >> 3)) + w[i-16];
		v = '{iv.a, iv.b, iv.c, iv.d, iv.e, iv.f, iv.g, iv.h};
		for (int i = 0; i < 64; i++) begin
			t1 = v[7] + (ror(v[4], 6) ^ ror(v[4], 11) ^ ror(v[4], 25))
				+ ((v[4] & v[5]) ^ (~v[4] & v[6])) + sha256_pkg::K_TABLE[i] + w[i];
			t2 = (ror(v[0], 2) ^ ror(v[0], 13) ^ ror(v[0], 22))
				+ ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
			v[7] = v[6];
			v[6] = v[5];
			v[5] = v[4];
			v[4] = v[3] + t1;
			v[3] = v[2];
			v[2] = v[1];
			v[1] = v[0];
			v[0] = t1 + t2;
		end
		return '{iv.a + v[0], iv.b + v[1], iv.c + v[2], iv.d + v[3],
			iv.e + v[4], iv.f + v[5], iv.g + v[6], iv.h + v[7]};
	endfunction

	function automatic sha256_pkg::hash_state_t double_hash(input int j,
		input miner_pkg::nonce_t n);
		sha256_pkg::word_t m [16];
		sha256_pkg::hash_state_t h1;
		sha256_pkg::hash_state_t iv;
		m = '{default: 32'h0};
		m[0] = j_tail[j];
		m[1] = j_time[j];
		m[2] = j_bits[j];
		m[3] = n;
		m[4] = 32'h8000_0000;
		m[15] = 32'd640; // Header is 80 bytes.
		h1 = compress(j_mid[j], m);
		m = '{h1.a, h1.b, h1.c, h1.d, h1.e, h1.f, h1.g, h1.h, 32'h8000_0000,
			32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'd256};
		iv = '{32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
			32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19};
		return compress(iv, m);
	endfunction

	task automatic check_hash(input sha256_pkg::hash_state_t got,
		input sha256_pkg::hash_state_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t %s: got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_nonce(input miner_pkg::nonce_t got, input miner_pkg::nonce_t exp,
		input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t %s: got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t %s: got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic read_trace();
		int fd;
		int rc;
		string line;
		sha256_pkg::word_t f [11];
		fd = $fopen("test/miner_trace.txt", "r");
		if (fd == 0) begin
			$display("cannot open test/miner_trace.txt");
			return;
		end
		while (!$feof(fd) && njobs < 8) begin
			line = "";
			rc = $fgets(line, fd);
			if (line.len() > 0 && line[0] != "#") begin
				rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %d %d", f[0], f[1],
					f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
					j_gap[njobs], j_delay[njobs]);
				if (rc == 13) begin
					j_mid[njobs] = '{f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]};
					j_tail[njobs] = f[8];
					j_time[njobs] = f[9];
					j_bits[njobs] = f[10];
					limit += 140 + j_delay[njobs];
					njobs++;
				end
			end
		end
		$fclose(fd);
	endtask

	always @(posedge clk)
		cyc <= cyc + 1;

	// Ends the run when the cycle limit is reached.
	always @(posedge clk) begin
		if (cyc >= limit && limit > 200) begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display("Something failed");
			$finish;
		end
	end

	// Monitor sampled at the falling edge, where all outputs are settled.
	int started = 0;
	int cur_job = -1;
	int res_cnt = 0;
	int issued = 0;
	int last_valid = 0;
	logic busy_prev = 1'b0;
	logic seen_valid = 1'b0;
	sha256_pkg::hash_state_t exp_hash;
	always @(negedge clk) begin
		if (started == 0) begin
			check_flag(busy_o, 1'b0, "busy_o before first job");
		end
		if (!seen_valid && !valid_o) begin
			check_flag(newblock_o, 1'b0, "newblock_o before first result");
			check_flag(hit_o, 1'b0, "hit_o before first result");
		end
		if (job_start_i && started < 8) begin
			j_start[started] = cyc;
			j_err[started] = errors;
			started++;
			issued = 0;
		end
		if (busy_o && run_i)
			issued++;
		if (busy_prev && !busy_o)
			check_nonce(issued, 16, "issues before busy_o fell");
		busy_prev = busy_o;
		if (valid_o) begin
			if (!seen_valid) begin
				seen_valid = 1'b1;
				$display("reset and idle outputs: done, %0d errors", errors);
			end
			if (cur_job < 0 || res_cnt == 16) begin
				check_flag(newblock_o, 1'b1, "newblock_o at first result");
				cur_job++;
				res_cnt = 0;
			end else begin
				check_flag(newblock_o, 1'b0, "newblock_o inside job");
			end
			if (cur_job >= njobs) begin
				errors++;
				$display("result arrived with no job left to match it");
			end else begin
				if (j_gap[cur_job] == 0 && res_cnt == 0)
					check_nonce(cyc - j_start[cur_job], 131, "first result latency");
				if (j_gap[cur_job] == 0 && res_cnt > 0)
					check_nonce(cyc - last_valid, 1, "result spacing");
				exp_hash = double_hash(cur_job, res_cnt);
				check_nonce(nonce_o, res_cnt, "nonce_o");
				check_hash(hash_o, exp_hash, "hash_o");
				check_flag(hit_o, (exp_hash.h[31:30] == 2'b00), "hit_o");
				res_cnt++;
				if (res_cnt == 16) begin
					jobs_done++;
					$display("job %0d: 16 results, %0d errors", cur_job,
						errors - j_err[cur_job]);
				end
			end
			last_valid = cyc;
		end
	end

	initial begin
		job_start_i = 1'b0;
		run_i = 1'b0;
		midstate_i = '0;
		merkle_tail_i = '0;
		timestamp_i = '0;
		bits_i = '0;
		read_trace();
		if (njobs == 0)
			errors++;
		wait (arst_n);
		for (int j = 0; j < njobs; j++) begin
			repeat (j_delay[j]) @(posedge clk);
			@(posedge clk);
			job_start_i <= 1'b1;
			midstate_i <= j_mid[j];
			merkle_tail_i <= j_tail[j];
			timestamp_i <= j_time[j];
			bits_i <= j_bits[j];
			run_i <= 1'b1;
			@(posedge clk);
			job_start_i <= 1'b0;
			@(negedge clk);
			while (busy_o) begin
				@(posedge clk);
				if (j_gap[j] != 0) begin
					lfsr = lfsr_step(lfsr);
					run_i <= lfsr[0];
				end else begin
					run_i <= 1'b1;
				end
				@(negedge clk);
			end
			@(posedge clk);
			run_i <= 1'b0;
		end
		wait (jobs_done == njobs);
		repeat (4) @(posedge clk);
		$display("tests %0d, checks %0d, errors %0d", jobs_done + 1, checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

//--- verilog.f
source/sha256_pkg.sv
source/miner_pkg.sv
source/sha_round_stage.sv
source/sha_pre_stage.sv
source/sha_pad_stage.sv
source/sha_double_core.sv
source/share_detector.sv
source/sha_miner_top.sv
test/clock_gen.sv
test/miner_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the miner testbench with Verilator, runs it and scans the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module miner_tb -f verilog.f -o miner_sim

./obj_dir/miner_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
	exit 1
fi
if ! grep -q "Everything OK" sim.log; then
	echo "simulation ended without a verdict"
	exit 1
fi
exit 0

//--- test/miner_trace.txt
# One job per line: midstate words a to h, merkle tail, timestamp, bits (hex),
# then gap (0 holds run_i high, 1 uses the LFSR mask) and idle cycles before start.
6a09e667 bb67ae85 3c6ef372 a54ff53a 510e527f 9b05688c 1f83d9ab 5be0cd19 4a5e1e4b 495fab29 1d00ffff 0 2
bc909a33 6358bff0 90ccac7d 1e59caa8 c3c8d8e9 4f0103c8 96b18736 4719f91b 0a7d2c11 5f1a3b44 1703a30c 1 3
12345678 9abcdef0 0fedcba9 87654321 deadbeef cafef00d 01234567 89abcdef 77aa55cc 60000001 1a01cd2d 0 0
00000001 00000002 00000003 00000004 00000005 00000006 00000007 00000008 ffffffff 5a5a5a5a 18ffffff 1 5
